// ==== evcap_macros.svh ====
// event capture constants for word, lane, beat, depth, timestamp and event widths
`ifndef EVCAP_MACROS_SVH
`define EVCAP_MACROS_SVH

// one ram word is one byte
`define EVCAP_WORD_BITS 8

// write lanes per cycle, also the size of a full record
`define EVCAP_LANES 4

// bytes per readout beat
`define EVCAP_OUT_FACTOR 4

// byte address width, 256-byte buffer
`define EVCAP_DEPTH_BITS 8

// free-running timestamp width
`define EVCAP_TS_BITS 24

// watched event lines, mask byte keeps its top bit for the compact flag
`define EVCAP_NUM_EVENTS 7

`endif

// ==== evcap_pkg.sv ====
// event capture types for the ram write lanes, the readout beat and the control state
`include "evcap_macros.svh"

package evcap_pkg;

   //////////////////////////////////////////////////////////////////////
   // ram write side
   //////////////////////////////////////////////////////////////////////

   // one record in flight, lane i lands at base+i
   typedef struct packed {
      // lane bytes, lane 0 holds the mask byte
      logic [`EVCAP_LANES-1:0][`EVCAP_WORD_BITS-1:0] data;
      // per-lane write enables
      logic [`EVCAP_LANES-1:0]                       en;
      // first byte address of the record
      logic [`EVCAP_DEPTH_BITS-1:0]                  base;
   } wr_lanes_t;

   //////////////////////////////////////////////////////////////////////
   // readout side
   //////////////////////////////////////////////////////////////////////

   // one readout beat, byte j at bits 8j+7:8j
   typedef struct packed {
      logic [`EVCAP_OUT_FACTOR*`EVCAP_WORD_BITS-1:0] data;
      // valid byte count, 1 to 4
      logic [2:0]                                    nbytes;
      // final beat of the stream
      logic                                          last;
   } rd_beat_t;

   //////////////////////////////////////////////////////////////////////
   // control
   //////////////////////////////////////////////////////////////////////

   // idle, capturing, streaming the buffer out
   typedef enum logic [1:0] {
      ST_IDLE  = 2'd0,
      ST_ARMED = 2'd1,
      ST_READ  = 2'd2
   } cap_state_t;

endpackage

// ==== evcap_timestamp.sv ====
// event capture timestamp, free-running counter with synchronous clear and enable
`timescale 1ns/1ps
`include "evcap_macros.svh"

module evcap_timestamp (
   input  logic                      clk,
   input  logic                      rst_n,
   // zero the count, wins over enable
   input  logic                      clear,
   // count one per cycle
   input  logic                      enable,
   output logic [`EVCAP_TS_BITS-1:0] ts
);

   localparam int TS_BITS = `EVCAP_TS_BITS;

   // counter register
   logic [TS_BITS-1:0] count;

   // wraps naturally at the full width
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         count <= '0;
      end else if (clear) begin
         count <= '0;
      end else if (enable) begin
         count <= count + TS_BITS'(1);
      end
   end

   // value seen by the packer in the detection cycle
   assign ts = count;

endmodule

// ==== evcap_record_packer.sv ====
// event capture record packer, edge detection, record build and ram write pointer
`timescale 1ns/1ps
`include "evcap_macros.svh"

module evcap_record_packer import evcap_pkg::*; (
   input  logic                         clk,
   input  logic                         rst_n,
   input  logic [`EVCAP_NUM_EVENTS-1:0] events,
   input  logic                         capture_en,
   // arm restart, clears pointer, overflow and previous record
   input  logic                         ptr_clear,
   input  logic [`EVCAP_TS_BITS-1:0]    ts,
   output wr_lanes_t                    wr_lanes,
   output logic [`EVCAP_DEPTH_BITS-1:0] wr_ptr,
   output logic                         overflow
);

   localparam int NEV     = `EVCAP_NUM_EVENTS;
   localparam int WB      = `EVCAP_WORD_BITS;
   localparam int DB      = `EVCAP_DEPTH_BITS;
   localparam int TS_BITS = `EVCAP_TS_BITS;
   localparam int HI_BITS = TS_BITS - WB;
   // last free slot kept back so the pointer never wraps to zero
   localparam logic [DB-1:0] PTR_LIMIT = DB'((1 << DB) - 1 - `EVCAP_LANES);

   //////////////////////////////////////////////////////////////////////
   // edge detection
   //////////////////////////////////////////////////////////////////////

   logic [NEV-1:0] ev_q;
   logic [NEV-1:0] ev_qq;
   logic [NEV-1:0] rise;

   // one input register plus one older copy
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         ev_q  <= '0;
         ev_qq <= '0;
      end else begin
         ev_q  <= events;
         ev_qq <= ev_q;
      end
   end

   assign rise = ev_q & ~ev_qq;

   //////////////////////////////////////////////////////////////////////
   // record build
   //////////////////////////////////////////////////////////////////////

   // upper timestamp bits of the last stored record
   logic [HI_BITS-1:0] prev_hi;
   logic               prev_valid;
   logic               hit;
   logic               compact;
   logic               has_room;
   logic               wr_rec;
   logic [DB-1:0]      rec_len;

   // a record is due on any rise while capturing
   assign hit      = capture_en && (rise != '0);
   assign has_room = (wr_ptr <= PTR_LIMIT);
   assign wr_rec   = hit && has_room;
   // same upper bits as the last record, low byte is enough
   assign compact  = prev_valid && (ts[TS_BITS-1:WB] == prev_hi);
   assign rec_len  = compact ? DB'(2) : DB'(4);

   // lane 0 mask byte with compact flag on top, then timestamp low first
   assign wr_lanes.data[0] = {compact, rise};
   assign wr_lanes.data[1] = ts[7:0];
   assign wr_lanes.data[2] = ts[15:8];
   assign wr_lanes.data[3] = ts[23:16];
   // compact record only takes lanes 0 and 1
   assign wr_lanes.en      = !wr_rec ? 4'b0000 : (compact ? 4'b0011 : 4'b1111);
   assign wr_lanes.base    = wr_ptr;

   // pointer, overflow and previous-record tracking
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wr_ptr     <= '0;
         overflow   <= 1'b0;
         prev_hi    <= '0;
         prev_valid <= 1'b0;
      end else if (ptr_clear) begin
         wr_ptr     <= '0;
         overflow   <= 1'b0;
         prev_valid <= 1'b0;
      end else if (wr_rec) begin
         wr_ptr     <= wr_ptr + rec_len;
         prev_hi    <= ts[TS_BITS-1:WB];
         prev_valid <= 1'b1;
      end else if (hit) begin
         // dropped record, sticky until next arm
         overflow   <= 1'b1;
      end
   end

endmodule

// ==== wide_port_ram.sv ====
// wide port ram, per-lane byte writes at consecutive addresses, segmented comb read
`timescale 1ns/1ps
`include "evcap_macros.svh"

module wide_port_ram import evcap_pkg::*; #(
   parameter int LANES      = `EVCAP_LANES,
   parameter int OUT_FACTOR = `EVCAP_OUT_FACTOR,
   parameter int DEPTH_BITS = `EVCAP_DEPTH_BITS
) (
   input  logic                                  clk,
   input  wr_lanes_t                             wr_lanes,
   input  logic [DEPTH_BITS-1:0]                 rd_addr,
   output logic [OUT_FACTOR*`EVCAP_WORD_BITS-1:0] rd_data
);

   localparam int WB    = `EVCAP_WORD_BITS;
   localparam int DEPTH = 1 << DEPTH_BITS;

   // byte storage, no reset
   logic [WB-1:0] ram_words [DEPTH];

   // per-lane write addresses
   logic [DEPTH_BITS-1:0] wr_addr_inc [LANES];
   // per-byte read addresses
   logic [DEPTH_BITS-1:0] rd_addr_inc [OUT_FACTOR];

   for (genvar i = 0; i < LANES; i++) begin : gen_wr_addr
      assign wr_addr_inc[i] = wr_lanes.base + DEPTH_BITS'(i);
   end

   // every enabled lane lands at base+i on the same edge
   always_ff @(posedge clk) begin
      for (int i = 0; i < LANES; i++) begin
         if (wr_lanes.en[i]) begin
            ram_words[wr_addr_inc[i]] <= wr_lanes.data[i];
         end
      end
   end

   //////////////////////////////////////////////////////////////////////
   // segmented read
   //////////////////////////////////////////////////////////////////////

   // byte j of the beat from rd_addr+j, wraps within the array
   for (genvar j = 0; j < OUT_FACTOR; j++) begin : gen_rd
      assign rd_addr_inc[j]         = rd_addr + DEPTH_BITS'(j);
      assign rd_data[WB*j +: WB]    = ram_words[rd_addr_inc[j]];
   end

endmodule

// ==== evcap_control_fsm.sv ====
// event capture control fsm, arm and disarm, readout address and beat framing
`timescale 1ns/1ps
`include "evcap_macros.svh"

module evcap_control_fsm import evcap_pkg::*; (
   input  logic                                   clk,
   input  logic                                   rst_n,
   input  logic                                   arm,
   input  logic                                   disarm,
   input  logic                                   rd_start,
   input  logic [`EVCAP_DEPTH_BITS-1:0]           wr_ptr,
   input  logic [`EVCAP_OUT_FACTOR*`EVCAP_WORD_BITS-1:0] rd_data,
   output logic                                   capture_en,
   output logic                                   ts_clear,
   output logic                                   ptr_clear,
   output logic                                   armed,
   output logic [`EVCAP_DEPTH_BITS-1:0]           rd_addr,
   output rd_beat_t                               rd_beat,
   output logic                                   rd_valid,
   output logic                                   rd_done
);

   localparam int DB   = `EVCAP_DEPTH_BITS;
   localparam int WB   = `EVCAP_WORD_BITS;
   localparam int OUTF = `EVCAP_OUT_FACTOR;
   localparam logic [DB-1:0] STEP = DB'(OUTF);

   cap_state_t    state;
   // bytes still below the write pointer
   logic [DB-1:0] remain;
   logic          beat_last;
   logic [2:0]    beat_bytes;
   logic          start_arm;

   //////////////////////////////////////////////////////////////////////
   // state register and read address
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state   <= ST_IDLE;
         rd_addr <= '0;
      end else begin
         case (state)
            ST_IDLE: begin
               // arm wins over a readout request
               if (arm) begin
                  state <= ST_ARMED;
               end else if (rd_start && (wr_ptr != '0)) begin
                  state   <= ST_READ;
                  rd_addr <= '0;
               end
            end
            ST_ARMED: begin
               // rd_start ignored here
               if (disarm) begin
                  state <= ST_IDLE;
               end
            end
            ST_READ: begin
               if (beat_last) begin
                  state <= ST_IDLE;
               end else begin
                  rd_addr <= rd_addr + STEP;
               end
            end
            default: state <= ST_IDLE;
         endcase
      end
   end

   // clears land on the edge that enters armed
   assign start_arm  = (state == ST_IDLE) && arm;
   assign ts_clear   = start_arm;
   assign ptr_clear  = start_arm;
   assign capture_en = (state == ST_ARMED);
   assign armed      = (state == ST_ARMED);

   //////////////////////////////////////////////////////////////////////
   // beat framing
   //////////////////////////////////////////////////////////////////////

   // rd_addr stays below wr_ptr while reading
   assign remain     = wr_ptr - rd_addr;
   assign beat_last  = (remain <= STEP);
   assign beat_bytes = beat_last ? remain[2:0] : 3'(OUTF);

   // bytes past the count forced to zero
   always_comb begin
      rd_beat.nbytes = beat_bytes;
      rd_beat.last   = beat_last;
      for (int j = 0; j < OUTF; j++) begin
         rd_beat.data[WB*j +: WB] = (3'(j) < beat_bytes) ? rd_data[WB*j +: WB] : '0;
      end
   end

   // one beat per cycle while streaming
   assign rd_valid = (state == ST_READ);
   assign rd_done  = rd_valid && beat_last;

endmodule

// ==== evcap_top.sv ====
// event capture top, timestamp, record packer, wide port ram and control fsm
`timescale 1ns/1ps
`include "evcap_macros.svh"

module evcap_top import evcap_pkg::*; (
   input  logic                         clk,
   input  logic                         rst_n,
   input  logic [`EVCAP_NUM_EVENTS-1:0] events,
   input  logic                         arm,
   input  logic                         disarm,
   input  logic                         rd_start,
   output rd_beat_t                     rd_beat,
   output logic                         rd_valid,
   output logic                         rd_done,
   output logic [`EVCAP_DEPTH_BITS-1:0] fill_level,
   output logic                         overflow,
   output logic                         armed
);

   // control to datapath
   logic                                          capture_en;
   logic                                          ts_clear;
   logic                                          ptr_clear;
   logic [`EVCAP_TS_BITS-1:0]                     ts;
   // ram ports
   wr_lanes_t                                     wr_lanes;
   logic [`EVCAP_DEPTH_BITS-1:0]                  wr_ptr;
   logic [`EVCAP_DEPTH_BITS-1:0]                  rd_addr;
   logic [`EVCAP_OUT_FACTOR*`EVCAP_WORD_BITS-1:0] rd_data;

   evcap_timestamp u_ts (
      .clk    (clk),
      .rst_n  (rst_n),
      .clear  (ts_clear),
      .enable (capture_en),
      .ts     (ts)
   );

   evcap_record_packer u_packer (
      .clk        (clk),
      .rst_n      (rst_n),
      .events     (events),
      .capture_en (capture_en),
      .ptr_clear  (ptr_clear),
      .ts         (ts),
      .wr_lanes   (wr_lanes),
      .wr_ptr     (wr_ptr),
      .overflow   (overflow)
   );

   wide_port_ram #(
      .LANES      (`EVCAP_LANES),
      .OUT_FACTOR (`EVCAP_OUT_FACTOR),
      .DEPTH_BITS (`EVCAP_DEPTH_BITS)
   ) u_ram (
      .clk      (clk),
      .wr_lanes (wr_lanes),
      .rd_addr  (rd_addr),
      .rd_data  (rd_data)
   );

   evcap_control_fsm u_fsm (
      .clk        (clk),
      .rst_n      (rst_n),
      .arm        (arm),
      .disarm     (disarm),
      .rd_start   (rd_start),
      .wr_ptr     (wr_ptr),
      .rd_data    (rd_data),
      .capture_en (capture_en),
      .ts_clear   (ts_clear),
      .ptr_clear  (ptr_clear),
      .armed      (armed),
      .rd_addr    (rd_addr),
      .rd_beat    (rd_beat),
      .rd_valid   (rd_valid),
      .rd_done    (rd_done)
   );

   // fill level is the write pointer
   assign fill_level = wr_ptr;

endmodule

// ==== evcap_properties.sv ====
// event capture assertions on lane enables, capture gating and readout done
`timescale 1ns/1ps
`include "evcap_macros.svh"

module evcap_properties import evcap_pkg::*; (
   input logic                    clk,
   input logic                    rst_n,
   input logic                    capture_en,
   input logic [`EVCAP_LANES-1:0] lane_en,
   input cap_state_t              state,
   input logic                    rd_valid,
   input logic                    rd_done
);

   // ram writes only while capturing
   a_en_in_capture: assert property (@(posedge clk) disable iff (!rst_n)
      (lane_en != '0) |-> capture_en)
      else $error("lane enable while capture is off");

   // compact or full record shape only
   a_en_shape: assert property (@(posedge clk) disable iff (!rst_n)
      (lane_en == 4'b0000) || (lane_en == 4'b0011) || (lane_en == 4'b1111))
      else $error("lane enables neither compact nor full");

   a_done_with_valid: assert property (@(posedge clk) disable iff (!rst_n)
      rd_done |-> rd_valid)
      else $error("rd_done without rd_valid");

   a_capture_armed: assert property (@(posedge clk) disable iff (!rst_n)
      (state != ST_ARMED) |-> !capture_en)
      else $error("capture enabled outside the armed state");

endmodule

// packer side, fsm-only inputs tied off
bind evcap_record_packer evcap_properties u_packer_props (
   .clk        (clk),
   .rst_n      (rst_n),
   .capture_en (capture_en),
   .lane_en    (wr_lanes.en),
   .state      (ST_ARMED),
   .rd_valid   (1'b0),
   .rd_done    (1'b0)
);

// fsm side, no lane enables here
bind evcap_control_fsm evcap_properties u_fsm_props (
   .clk        (clk),
   .rst_n      (rst_n),
   .capture_en (capture_en),
   .lane_en    (4'b0000),
   .state      (state),
   .rd_valid   (rd_valid),
   .rd_done    (rd_done)
);

// ==== tb_evcap.sv ====
// event capture testbench, directed tests checked against a byte-queue reference model
`timescale 1ns/1ps
`include "evcap_macros.svh"

module tb_evcap import evcap_pkg::*; ();

   logic                         clk;
   logic                         rst_n;
   logic [`EVCAP_NUM_EVENTS-1:0] events;
   logic                         arm;
   logic                         disarm;
   logic                         rd_start;
   rd_beat_t                     rd_beat;
   logic                         rd_valid;
   logic                         rd_done;
   logic [`EVCAP_DEPTH_BITS-1:0] fill_level;
   logic                         overflow;
   logic                         armed;

   // lcg state
   logic [31:0] seed = 32'h261e36d3;
   // edge count, edge of the arm pulse
   int          cyc;
   int          arm_cyc;
   // reference model
   int          model_ptr;
   logic        model_ovf;
   logic        prev_valid;
   logic [15:0] prev_hi;
   logic [7:0]  model_q[$];
   logic [7:0]  got_q[$];

   always #5 clk = ~clk;

   evcap_top u_dut (.*);

   //////////////////////////////////////////////////////////////////////
   // helpers
   //////////////////////////////////////////////////////////////////////

   function automatic logic [31:0] lcg_next();
      seed = seed * 32'd1664525 + 32'd1013904223;
      return seed;
   endfunction

   // nonzero mask over the seven lines
   function automatic logic [6:0] rand_mask();
      logic [31:0] r;
      r = lcg_next();
      return (r[22:16] == 7'h00) ? 7'h01 : r[22:16];
   endfunction

   task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp) begin
         $display("FAIL %s got 0x%0h expected 0x%0h", name, got, exp);
         $display("TEST FAILED");
         $fatal(1, "value mismatch");
      end
   endtask

   task automatic fail_wait(input string what);
      $display("timed out waiting for %s", what);
      $display("TEST FAILED");
      $fatal(1, "wait timed out");
   endtask

   task automatic step();
      @(posedge clk);
      cyc++;
   endtask

   // one record, full unless upper ts bits repeat; needs a spare slot on top
   task automatic model_record(input logic [6:0] mask, input logic [23:0] ts);
      logic compact;
      if (model_ptr + 4 < 256) begin
         compact = prev_valid && (ts[23:8] == prev_hi);
         model_q.push_back({compact, mask});
         model_q.push_back(ts[7:0]);
         if (!compact) begin
            model_q.push_back(ts[15:8]);
            model_q.push_back(ts[23:16]);
         end
         model_ptr += compact ? 2 : 4;
         prev_hi    = ts[23:8];
         prev_valid = 1'b1;
      end else begin
         model_ovf = 1'b1;
      end
   endtask

   // one-cycle pulse, ts is edges since the arm pulse
   task automatic pulse_events(input logic [6:0] mask, input int gap);
      step();
      events <= mask;
      model_record(mask, 24'(cyc - arm_cyc));
      step();
      events <= '0;
      repeat (gap) step();
   endtask

   task automatic arm_capture();
      step();
      arm       <= 1'b1;
      arm_cyc    = cyc;
      model_ptr  = 0;
      model_ovf  = 1'b0;
      prev_valid = 1'b0;
      model_q.delete();
      step();
      arm <= 1'b0;
      @(negedge clk);
      check("armed", 32'(armed), 1);
   endtask

   task automatic disarm_capture();
      step();
      disarm <= 1'b1;
      step();
      disarm <= 1'b0;
      @(negedge clk);
      check("armed", 32'(armed), 0);
   endtask

   // stream the buffer, framing checked beat by beat, bytes against the model
   task automatic read_buffer();
      int   tries;
      int   beats;
      int   remain;
      logic done;
      got_q.delete();
      tries = 0;
      beats = 0;
      done  = 1'b0;
      step();
      rd_start <= 1'b1;
      step();
      rd_start <= 1'b0;
      @(negedge clk);
      while (!rd_valid) begin
         tries++;
         if (tries > 8) fail_wait("first readout beat");
         @(negedge clk);
      end
      check("first beat delay", 32'(tries), 0);
      while (!done) begin
         remain = model_ptr - 4 * beats;
         check("rd_valid", 32'(rd_valid), 1);
         check("rd_beat.nbytes", 32'(rd_beat.nbytes), (remain < 4) ? remain : 4);
         check("rd_beat.last", 32'(rd_beat.last), 32'(remain <= 4));
         check("rd_done", 32'(rd_done), 32'(remain <= 4));
         for (int j = 0; j < int'(rd_beat.nbytes); j++) begin
            got_q.push_back(rd_beat.data[8*j +: 8]);
         end
         beats++;
         if (rd_beat.last) begin
            done = 1'b1;
         end else begin
            if (beats >= 64) fail_wait("last readout beat");
            @(negedge clk);
         end
      end
      check("beat count", 32'(beats), 32'((model_ptr + 3) / 4));
      check("byte count", 32'(got_q.size()), 32'(model_q.size()));
      foreach (model_q[i]) begin
         check($sformatf("ram byte %0d", i), 32'(got_q[i]), 32'(model_q[i]));
      end
      @(negedge clk);
      check("rd_valid after last", 32'(rd_valid), 0);
   endtask

   //////////////////////////////////////////////////////////////////////
   // tests
   //////////////////////////////////////////////////////////////////////

   task automatic idle_after_reset();
      @(negedge clk);
      check("armed", 32'(armed), 0);
      check("rd_valid", 32'(rd_valid), 0);
      check("overflow", 32'(overflow), 0);
      check("fill_level", 32'(fill_level), 0);
      // empty buffer, no stream
      step();
      rd_start <= 1'b1;
      step();
      rd_start <= 1'b0;
      repeat (8) begin
         @(negedge clk);
         check("rd_valid", 32'(rd_valid), 0);
      end
   endtask

   task automatic single_full_record();
      arm_capture();
      pulse_events(7'b0100101, 3);
      disarm_capture();
      check("fill_level", 32'(fill_level), 4);
      read_buffer();
      check("mask byte", 32'(got_q[0]), 32'({1'b0, 7'b0100101}));
   endtask

   task automatic compact_deltas();
      int         gaps[10];
      int         idx;
      logic [7:0] lo_prev;
      foreach (gaps[i]) gaps[i] = 1 + int'(lcg_next() >> 29);
      arm_capture();
      foreach (gaps[i]) pulse_events(rand_mask(), gaps[i]);
      disarm_capture();
      check("fill_level", 32'(fill_level), 32'(model_ptr));
      check("fill_level", 32'(fill_level), 22);
      read_buffer();
      lo_prev = got_q[1];
      // records after the first are compact, two bytes each
      for (int k = 1; k < 10; k++) begin
         idx = 4 + 2 * (k - 1);
         check("compact flag", 32'(got_q[idx][7]), 1);
         check("ts delta", 32'(8'(got_q[idx+1] - lo_prev)), 32'(8'(gaps[k-1] + 2)));
         lo_prev = got_q[idx+1];
      end
   endtask

   task automatic segmented_framing();
      int n;
      // odd count of compact records keeps the fill off a multiple of 4
      n = 1 + 2 * int'(lcg_next() >> 30);
      arm_capture();
      pulse_events(rand_mask(), 2);
      repeat (n) pulse_events(rand_mask(), 1);
      disarm_capture();
      check("fill_level", 32'(fill_level), 32'(4 + 2 * n));
      read_buffer();
   endtask

   task automatic overflow_and_rearm();
      int guard;
      guard = 0;
      arm_capture();
      while (!model_ovf) begin
         guard++;
         if (guard > 400) fail_wait("buffer overflow");
         pulse_events(rand_mask(), 1);
      end
      @(negedge clk);
      check("fill_level", 32'(fill_level), 32'(model_ptr));
      check("overflow", 32'(overflow), 1);
      disarm_capture();
      check("overflow", 32'(overflow), 1);
      read_buffer();
      arm_capture();
      check("overflow", 32'(overflow), 0);
      check("fill_level", 32'(fill_level), 0);
      disarm_capture();
   endtask

   task automatic ignored_inputs();
      arm_capture();
      pulse_events(rand_mask(), 2);
      // readout request while capturing
      step();
      rd_start <= 1'b1;
      step();
      rd_start <= 1'b0;
      repeat (6) begin
         @(negedge clk);
         check("rd_valid", 32'(rd_valid), 0);
      end
      check("armed", 32'(armed), 1);
      disarm_capture();
      // edges after disarm add nothing
      step();
      events <= 7'h7f;
      step();
      events <= '0;
      repeat (3) step();
      @(negedge clk);
      check("fill_level", 32'(fill_level), 32'(model_ptr));
      read_buffer();
   endtask

   initial begin
      clk        = 1'b0;
      rst_n      = 1'b0;
      events     = '0;
      arm        = 1'b0;
      disarm     = 1'b0;
      rd_start   = 1'b0;
      cyc        = 0;
      arm_cyc    = 0;
      model_ptr  = 0;
      model_ovf  = 1'b0;
      prev_valid = 1'b0;
      prev_hi    = '0;
      repeat (2) @(posedge clk);
      rst_n <= 1'b1;
      idle_after_reset();
      single_full_record();
      compact_deltas();
      segmented_framing();
      overflow_and_rearm();
      ignored_inputs();
      $display("TEST OK");
      $finish;
   end

endmodule

// ==== evcap_top.f ====
+incdir+.
evcap_pkg.sv
evcap_timestamp.sv
evcap_record_packer.sv
wide_port_ram.sv
evcap_control_fsm.sv
evcap_top.sv
evcap_properties.sv
tb_evcap.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the event capture testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module tb_evcap -f evcap_top.f --Mdir obj_dir -o sim_evcap

# the log decides pass or fail
./obj_dir/sim_evcap > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST FAILED" sim.log; then
   echo "simulation reported a failure, see sim.log"
   exit 1
fi
if ! grep -q "TEST OK" sim.log; then
   echo "simulation ended without a pass report, see sim.log"
   exit 1
fi
